//--- design/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// byte address of the first fetch after reset
`define CORE_RESET_PC 32'h0000_0000

// architectural registers, x0 included
`define CORE_NUM_REGS 32

// instruction memory depth in words
`define CORE_IMEM_WORDS 64

`endif

//--- design/core_pkg.sv
package core_pkg;

   // major opcodes of the supported subset
   typedef enum logic [6:0] {
      OP_LOAD   = 7'b0000011,
      OP_IMM    = 7'b0010011,
      OP_STORE  = 7'b0100011,
      OP_REG    = 7'b0110011,
      OP_LUI    = 7'b0110111,
      OP_BRANCH = 7'b1100011,
      OP_JAL    = 7'b1101111
   } opcode_e;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLL,
      ALU_SRL,
      ALU_PASS_B     // lui
   } alu_op_e;

   typedef struct packed {
      logic [31:2] pc;        // word address
      logic [31:0] instr;
   } fd_t;

   typedef struct packed {
      logic [31:2] pc;
      logic [31:0] rs1_val;
      logic [31:0] rs2_val;
      logic [31:0] imm;
      alu_op_e     alu_op;
      logic        use_imm;   // operand b from imm instead of rs2
      logic        rf_we;
      logic        is_load;
      logic        is_store;
      logic        is_byte;   // sb
      logic        is_bne;
      logic        is_branch;
      logic        is_jump;
      logic [4:0]  rd;
   } de_t;

   typedef struct packed {
      logic [31:0] result;    // alu result or memory address
      logic [31:0] store_data;
      logic        is_byte;
      logic        is_load;
      logic        is_store;
      logic        rf_we;
      logic [4:0]  rd;
   } er_t;

endpackage

//--- design/stage_if.sv
`timescale 1ns/1ps

interface stage_if #(
   parameter type payload_t = logic
) ();

   logic     valid;
   logic     ready;
   payload_t payload;
   logic     flush;      // squash request for the consumer's output register

   modport src (
      output valid, payload, flush,
      input  ready
   );

   modport dst (
      input  valid, payload, flush,
      output ready
   );

   // passive view for checkers and monitors
   modport mon (
      input valid, ready, payload, flush
   );

endinterface

//--- design/fetch_stage.sv
`timescale 1ns/1ps
`include "core_params.svh"

module fetch_stage (
   input  logic        clk_i,
   input  logic        arst_n_i,
   input  logic        instr_blocking_n_i,
   input  logic [31:0] instr_data_i,
   output logic [31:2] instr_addr_o,
   input  logic        redirect_i,
   input  logic [31:2] redirect_pc_i,
   stage_if.src        fd_o
);

   localparam logic [31:0] RESET_PC = `CORE_RESET_PC;

   logic [31:2]   pc_q;
   logic [31:2]   pend_pc_q;
   logic          pend_q;    // redirect parked until the port unblocks
   logic          valid_q;
   core_pkg::fd_t fd_q;
   logic          take;

   assign instr_addr_o = pc_q;
   assign take         = instr_blocking_n_i & ~pend_q & (~valid_q | fd_o.ready);

   assign fd_o.valid   = valid_q;
   assign fd_o.payload = fd_q;
   assign fd_o.flush   = redirect_i;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pc_q    <= RESET_PC[31:2];
         pend_q  <= 1'b0;
         valid_q <= 1'b0;
      end else if (redirect_i) begin
         valid_q <= 1'b0;                 // drop the buffered word
         if (instr_blocking_n_i) begin
            pc_q   <= redirect_pc_i;
            pend_q <= 1'b0;
         end else begin
            pend_q <= 1'b1;               // address must hold while blocked
         end
      end else if (pend_q) begin
         if (instr_blocking_n_i) begin
            pc_q   <= pend_pc_q;
            pend_q <= 1'b0;
         end
      end else if (take) begin
         valid_q <= 1'b1;
         pc_q    <= pc_q + 30'd1;
      end else if (fd_o.ready) begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (redirect_i) begin
         pend_pc_q <= redirect_pc_i;
      end
      if (take) begin
         fd_q.pc    <= pc_q;
         fd_q.instr <= instr_data_i;
      end
   end

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps
`include "core_params.svh"

module decode_stage (
   input  logic        clk_i,
   input  logic        arst_n_i,
   stage_if.dst        fd_i,
   stage_if.src        de_o,
   input  logic        wb_en_i,
   input  logic [4:0]  wb_rd_i,
   input  logic [31:0] wb_data_i,
   input  logic [4:0]  busy_rd_ex_i,
   input  logic [4:0]  busy_rd_res_i
);

   logic [31:0]       regs [`CORE_NUM_REGS];
   logic [31:0]       instr;
   logic [4:0]        rs1;
   logic [4:0]        rs2;
   logic [4:0]        res_rd;
   logic [31:0]       rs1_val;
   logic [31:0]       rs2_val;
   logic [31:0]       imm_i;
   logic [31:0]       imm_s;
   logic [31:0]       imm_b;
   logic [31:0]       imm_j;
   logic [31:0]       imm_u;
   logic              use_rs1;
   logic              use_rs2;
   logic              hazard;
   logic              arith_ok;
   logic              de_valid_q;
   core_pkg::alu_op_e arith_op;
   core_pkg::opcode_e opc;
   core_pkg::de_t     dec;
   core_pkg::de_t     de_q;

   assign instr = fd_i.payload.instr;
   assign opc   = core_pkg::opcode_e'(instr[6:0]);
   assign rs1   = instr[19:15];
   assign rs2   = instr[24:20];

   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
   assign imm_u = {instr[31:12], 12'd0};

   // register file, write-first so a retiring value is seen the same cycle
   always_ff @(posedge clk_i) begin
      if (wb_en_i && wb_rd_i != 5'd0) begin
         regs[wb_rd_i] <= wb_data_i;
      end
   end

   assign rs1_val = (rs1 == 5'd0) ? 32'd0 :
                    (wb_en_i && wb_rd_i == rs1) ? wb_data_i : regs[rs1];
   assign rs2_val = (rs2 == 5'd0) ? 32'd0 :
                    (wb_en_i && wb_rd_i == rs2) ? wb_data_i : regs[rs2];

   // a producer retiring this cycle no longer blocks, its value is bypassed
   assign res_rd = (wb_en_i && wb_rd_i == busy_rd_res_i) ? 5'd0 : busy_rd_res_i;
   assign hazard = (use_rs1 && rs1 != 5'd0 && (rs1 == busy_rd_ex_i || rs1 == res_rd)) ||
                   (use_rs2 && rs2 != 5'd0 && (rs2 == busy_rd_ex_i || rs2 == res_rd));

   // shared by register and immediate arithmetic
   always_comb begin
      arith_ok = 1'b1;
      arith_op = core_pkg::ALU_ADD;
      case (instr[14:12])
         3'b000: arith_op = (opc == core_pkg::OP_REG && instr[30]) ? core_pkg::ALU_SUB
                                                                     : core_pkg::ALU_ADD;
         3'b001: arith_op = core_pkg::ALU_SLL;
         3'b010: arith_op = core_pkg::ALU_SLT;
         3'b100: arith_op = core_pkg::ALU_XOR;
         3'b101: begin
            arith_op = core_pkg::ALU_SRL;
            arith_ok = ~instr[30];        // sra not supported
         end
         3'b110: arith_op = core_pkg::ALU_OR;
         3'b111: arith_op = core_pkg::ALU_AND;
         default: arith_ok = 1'b0;        // sltu
      endcase
   end

   always_comb begin
      dec         = '0;
      use_rs1     = 1'b0;
      use_rs2     = 1'b0;
      dec.pc      = fd_i.payload.pc;
      dec.rs1_val = rs1_val;
      dec.rs2_val = rs2_val;
      dec.rd      = instr[11:7];
      dec.alu_op  = core_pkg::ALU_ADD;
      case (opc)
         core_pkg::OP_LUI: begin
            dec.imm     = imm_u;
            dec.alu_op  = core_pkg::ALU_PASS_B;
            dec.use_imm = 1'b1;
            dec.rf_we   = 1'b1;
         end
         core_pkg::OP_JAL: begin
            dec.imm     = imm_j;
            dec.is_jump = 1'b1;
            dec.rf_we   = 1'b1;
         end
         core_pkg::OP_BRANCH: begin
            dec.imm       = imm_b;
            use_rs1       = 1'b1;
            use_rs2       = 1'b1;
            dec.is_branch = (instr[14:13] == 2'b00);   // beq, bne
            dec.is_bne    = instr[12];
         end
         core_pkg::OP_LOAD: begin
            dec.imm     = imm_i;
            dec.use_imm = 1'b1;
            use_rs1     = 1'b1;
            dec.is_load = (instr[14:12] == 3'b010);   // lw only
            dec.rf_we   = (instr[14:12] == 3'b010);
         end
         core_pkg::OP_STORE: begin
            dec.imm      = imm_s;
            dec.use_imm  = 1'b1;
            use_rs1      = 1'b1;
            use_rs2      = 1'b1;
            dec.is_store = (instr[14:12] == 3'b010) || (instr[14:12] == 3'b000);
            dec.is_byte  = (instr[14:12] == 3'b000);
         end
         core_pkg::OP_IMM: begin
            dec.imm     = imm_i;
            dec.use_imm = 1'b1;
            dec.alu_op  = arith_op;
            dec.rf_we   = arith_ok;
            use_rs1     = 1'b1;
         end
         core_pkg::OP_REG: begin
            dec.alu_op = arith_op;
            dec.rf_we  = arith_ok;
            use_rs1    = 1'b1;
            use_rs2    = 1'b1;
         end
         default: ;   // anything else goes down the pipe as a nop
      endcase
   end

   assign fd_i.ready   = (~de_valid_q | de_o.ready) & ~hazard;
   assign de_o.valid   = de_valid_q;
   assign de_o.payload = de_q;
   assign de_o.flush   = fd_i.flush;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         de_valid_q <= 1'b0;
      end else if (fd_i.flush) begin
         de_valid_q <= 1'b0;   // younger than a taken branch
      end else if (fd_i.valid && fd_i.ready) begin
         de_valid_q <= 1'b1;
      end else if (de_o.ready) begin
         de_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fd_i.valid && fd_i.ready) begin
         de_q <= dec;
      end
   end

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
   input  logic        clk_i,
   input  logic        arst_n_i,
   stage_if.dst        de_i,
   stage_if.src        er_o,
   output logic        redirect_o,
   output logic [31:2] redirect_pc_o,
   output logic [4:0]  busy_rd_o
);

   core_pkg::de_t d;
   core_pkg::er_t er_q;
   logic [31:0]   op_b;
   logic [31:0]   alu_res;
   logic [31:0]   pc_byte;
   logic [31:0]   target;
   logic          taken;
   logic          move;
   logic          er_valid_q;

   assign d       = de_i.payload;
   assign op_b    = d.use_imm ? d.imm : d.rs2_val;
   assign pc_byte = {d.pc, 2'b00};
   assign target  = pc_byte + d.imm;   // branch and jal target

   always_comb begin
      case (d.alu_op)
         core_pkg::ALU_ADD:    alu_res = d.rs1_val + op_b;
         core_pkg::ALU_SUB:    alu_res = d.rs1_val - op_b;
         core_pkg::ALU_AND:    alu_res = d.rs1_val & op_b;
         core_pkg::ALU_OR:     alu_res = d.rs1_val | op_b;
         core_pkg::ALU_XOR:    alu_res = d.rs1_val ^ op_b;
         core_pkg::ALU_SLT:    alu_res = {31'd0, $signed(d.rs1_val) < $signed(op_b)};
         core_pkg::ALU_SLL:    alu_res = d.rs1_val << op_b[4:0];
         core_pkg::ALU_SRL:    alu_res = d.rs1_val >> op_b[4:0];
         core_pkg::ALU_PASS_B: alu_res = op_b;
         default:              alu_res = 32'd0;
      endcase
   end

   // beq when equal, bne when not
   assign taken = d.is_jump | (d.is_branch & ((d.rs1_val == d.rs2_val) ^ d.is_bne));

   assign de_i.ready = ~er_valid_q | er_o.ready;
   assign move       = de_i.valid & de_i.ready;

   // redirect only in the cycle the branch moves on to result
   assign redirect_o    = move & taken;
   assign redirect_pc_o = target[31:2];
   assign busy_rd_o     = (de_i.valid && d.rf_we) ? d.rd : 5'd0;

   assign er_o.valid   = er_valid_q;
   assign er_o.payload = er_q;
   assign er_o.flush   = 1'b0;   // nothing downstream is ever squashed

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         er_valid_q <= 1'b0;
      end else if (move) begin
         er_valid_q <= 1'b1;
      end else if (er_o.ready) begin
         er_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (move) begin
         er_q.result     <= d.is_jump ? pc_byte + 32'd4 : alu_res;   // jal links pc+4
         er_q.store_data <= d.rs2_val;
         er_q.is_byte    <= d.is_byte;
         er_q.is_load    <= d.is_load;
         er_q.is_store   <= d.is_store;
         er_q.rf_we      <= d.rf_we;
         er_q.rd         <= d.rd;
      end
   end

endmodule

//--- design/result_stage.sv
`timescale 1ns/1ps

module result_stage (
   input  logic        clk_i,
   input  logic        arst_n_i,
   stage_if.dst        er_i,
   input  logic        data_blocking_n_i,
   input  logic [31:0] data_rdata_i,
   output logic [31:2] data_addr_o,
   output logic [3:0]  data_we_o,
   output logic [31:0] data_wdata_o,
   output logic        data_en_o,
   output logic        wb_en_o,
   output logic [4:0]  wb_rd_o,
   output logic [31:0] wb_data_o,
   output logic [4:0]  busy_rd_o
);

   logic        mem_op;
   logic        done;
   logic        retire;

   assign mem_op    = er_i.payload.is_load | er_i.payload.is_store;
   assign data_en_o = er_i.valid & mem_op;
   assign data_addr_o = er_i.payload.result[31:2];

   always_comb begin
      data_we_o = 4'b0000;
      if (er_i.valid && er_i.payload.is_store) begin
         data_we_o = er_i.payload.is_byte ? (4'b0001 << er_i.payload.result[1:0])
                                          : 4'b1111;
      end
   end

   // sb puts the byte on every lane and the enable picks one
   assign data_wdata_o = er_i.payload.is_byte ? {4{er_i.payload.store_data[7:0]}}
                                              : er_i.payload.store_data;

   // a memory access holds the stage until the port unblocks
   assign done       = ~mem_op | data_blocking_n_i;
   assign er_i.ready = done;
   assign retire     = er_i.valid & done;

   assign wb_en_o   = retire & er_i.payload.rf_we;
   assign wb_rd_o   = er_i.payload.rd;
   assign wb_data_o = er_i.payload.is_load ? data_rdata_i : er_i.payload.result;
   assign busy_rd_o = (er_i.valid && er_i.payload.rf_we) ? er_i.payload.rd : 5'd0;

endmodule

//--- design/core.sv
`timescale 1ns/1ps

module core (
   input  logic        clk_i,
   input  logic        arst_n_i,
   input  logic        instr_blocking_n_i,
   input  logic [31:0] instr_data_i,
   input  logic        data_blocking_n_i,
   input  logic [31:0] data_rdata_i,
   output logic [31:2] instr_addr_o,
   output logic [31:2] data_addr_o,
   output logic [3:0]  data_we_o,
   output logic [31:0] data_wdata_o,
   output logic        data_en_o
);

   logic        redirect;
   logic [31:2] redirect_pc;
   logic        wb_en;
   logic [4:0]  wb_rd;
   logic [31:0] wb_data;
   logic [4:0]  busy_rd_ex;    // rd waiting in execute
   logic [4:0]  busy_rd_res;   // rd waiting in result

   stage_if #(.payload_t(core_pkg::fd_t)) fd_link ();
   stage_if #(.payload_t(core_pkg::de_t)) de_link ();
   stage_if #(.payload_t(core_pkg::er_t)) er_link ();

   fetch_stage u_fetch (
      .clk_i              (clk_i),
      .arst_n_i           (arst_n_i),
      .instr_blocking_n_i (instr_blocking_n_i),
      .instr_data_i       (instr_data_i),
      .instr_addr_o       (instr_addr_o),
      .redirect_i         (redirect),
      .redirect_pc_i      (redirect_pc),
      .fd_o               (fd_link)
   );

   decode_stage u_decode (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .fd_i          (fd_link),
      .de_o          (de_link),
      .wb_en_i       (wb_en),
      .wb_rd_i       (wb_rd),
      .wb_data_i     (wb_data),
      .busy_rd_ex_i  (busy_rd_ex),
      .busy_rd_res_i (busy_rd_res)
   );

   execute_stage u_execute (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .de_i          (de_link),
      .er_o          (er_link),
      .redirect_o    (redirect),
      .redirect_pc_o (redirect_pc),
      .busy_rd_o     (busy_rd_ex)
   );

   result_stage u_result (
      .clk_i             (clk_i),
      .arst_n_i          (arst_n_i),
      .er_i              (er_link),
      .data_blocking_n_i (data_blocking_n_i),
      .data_rdata_i      (data_rdata_i),
      .data_addr_o       (data_addr_o),
      .data_we_o         (data_we_o),
      .data_wdata_o      (data_wdata_o),
      .data_en_o         (data_en_o),
      .wb_en_o           (wb_en),
      .wb_rd_o           (wb_rd),
      .wb_data_o         (wb_data),
      .busy_rd_o         (busy_rd_res)
   );

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
   parameter time PERIOD = 10ns
) (
   output logic clk_o
);

   initial clk_o = 1'b0;
   always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

//--- tb/core_props.sv
`timescale 1ns/1ps
`include "core_params.svh"

module core_props (
   input logic        clk_i,
   input logic        arst_n_i,
   input logic        instr_blocking_n_i,
   input logic        data_blocking_n_i,
   input logic [31:2] instr_addr_o,
   input logic [31:2] data_addr_o,
   input logic [3:0]  data_we_o,
   input logic [31:0] data_wdata_o,
   input logic        data_en_o
);

   localparam logic [31:0] RESET_PC = `CORE_RESET_PC;

   int unsigned fail_cnt = 0;   // read by the testbench top

   reset_state: assert property (@(posedge clk_i)
      !arst_n_i |-> instr_addr_o == RESET_PC[31:2] && !data_en_o && data_we_o == 4'd0)
      else begin $error("outputs not idle in reset"); fail_cnt++; end

   we_needs_en: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      data_we_o != 4'd0 |-> data_en_o)
      else begin $error("write enable without data_en_o"); fail_cnt++; end

   lanes_legal: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      data_we_o != 4'd0 |-> $countones(data_we_o) == 1 || data_we_o == 4'hf)
      else begin $error("illegal byte enable pattern"); fail_cnt++; end

   data_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      data_en_o && !data_blocking_n_i |=>
         $stable(data_addr_o) && $stable(data_we_o) && $stable(data_wdata_o))
      else begin $error("data request changed while blocked"); fail_cnt++; end

   instr_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !instr_blocking_n_i |=> $stable(instr_addr_o))
      else begin $error("fetch address changed while blocked"); fail_cnt++; end

endmodule

bind core core_props props_i (.*);

//--- tb/core_tb.sv
`timescale 1ns/1ps
`include "core_params.svh"

module core_tb;

   localparam int LIMIT = `CORE_IMEM_WORDS * 40;
   // stores to byte 16 are markers behind taken branches
   // the store to byte 60 ends the program
   localparam logic [31:0] PROG [31] = '{
      32'h123450b7, 32'h06400113, 32'h002081b3, 32'h00302023, 32'h40218233,
      32'h00402223, 32'h00002283, 32'h00429313, 32'h00602423, 32'h002006a3,
      32'h00000463, 32'h00102823, 32'h00009463, 32'h00102823, 32'h008003ef,
      32'h00102823, 32'h0011f433, 32'h007464b3, 32'hfff4c513, 32'h002525b3,
      32'h00355613, 32'h00c586b3, 32'h00d02a23, 32'h0f06e713, 32'h0ff77793,
      32'h1007a813, 32'h010798b3, 32'h0108d933, 32'h00d94933, 32'h03202e23,
      32'h0000006f};

   logic        clk_i;
   logic        arst_n_i;
   logic        instr_blocking_n_i;
   logic [31:0] instr_data_i;
   logic        data_blocking_n_i;
   logic [31:0] data_rdata_i;
   logic [31:2] instr_addr_o;
   logic [31:2] data_addr_o;
   logic [3:0]  data_we_o;
   logic [31:0] data_wdata_o;
   logic        data_en_o;

   logic [31:0] imem [`CORE_IMEM_WORDS];
   logic [31:0] dmem [16];
   logic [29:0] exp_addr [$];
   logic [3:0]  exp_we [$];
   logic [31:0] exp_data [$];
   int          errors = 0;
   int          iblk_cnt = 0;
   int          dblk_cnt = 0;
   logic        done = 1'b0;

   tb_clock clk_gen (.clk_o(clk_i));

   core dut (.*);

   // instruction set semantics of the arithmetic subset
   function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                           input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'd0: return sub ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return {31'd0, $signed(a) < $signed(b)};
         3'd4: return a ^ b;
         3'd5: return a >> b[4:0];
         3'd6: return a | b;
         3'd7: return a & b;
         default: return 32'd0;
      endcase
   endfunction

   task automatic run_reference();
      logic [31:0] x [32];
      logic [7:0]  mem [64];
      logic [31:0] pc;
      logic [31:0] nxt;
      logic [31:0] ins;
      logic [31:0] r;
      logic [31:0] addr;
      logic [31:0] imm_i;
      logic [3:0]  we;
      logic [31:0] wd;
      logic        wr;
      logic        fin;
      fin = 1'b0;
      pc  = `CORE_RESET_PC;
      foreach (x[i]) x[i] = 32'd0;
      foreach (mem[i]) mem[i] = 8'd0;
      for (int step = 0; step < 500 && !fin; step++) begin
         ins   = imem[pc[7:2]];
         imm_i = {{20{ins[31]}}, ins[31:20]};
         nxt   = pc + 32'd4;
         wr    = 1'b1;
         r     = 32'd0;
         case (ins[6:0])
            7'h37: r = {ins[31:12], 12'd0};
            7'h13: r = alu_ref(ins[14:12], 1'b0, x[ins[19:15]], imm_i);
            7'h33: r = alu_ref(ins[14:12], ins[30], x[ins[19:15]], x[ins[24:20]]);
            7'h03: begin
               addr = x[ins[19:15]] + imm_i;
               r = {mem[addr[5:0] + 6'd3], mem[addr[5:0] + 6'd2],
                    mem[addr[5:0] + 6'd1], mem[addr[5:0]]};
            end
            7'h23: begin
               wr   = 1'b0;
               addr = x[ins[19:15]] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
               r    = x[ins[24:20]];
               exp_addr.push_back(addr[31:2]);
               if (ins[14:12] == 3'd0) begin   // sb
                  mem[addr[5:0]] = r[7:0];
                  for (int l = 0; l < 4; l++) begin
                     we[l]        = (addr[1:0] == 2'(l));
                     wd[8*l +: 8] = r[7:0];
                  end
                  exp_we.push_back(we);
                  exp_data.push_back(wd);
               end else begin
                  for (int l = 0; l < 4; l++) mem[addr[5:0] + 6'(l)] = r[8*l +: 8];
                  exp_we.push_back(4'hf);
                  exp_data.push_back(r);
               end
               fin = (addr == 32'd60);
            end
            7'h63: begin
               wr = 1'b0;
               if ((x[ins[19:15]] == x[ins[24:20]]) != ins[12])
                  nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            7'h6f: begin
               r   = pc + 32'd4;
               nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: wr = 1'b0;
         endcase
         if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = r;
         pc = nxt;
      end
   endtask

   // blocking inputs and memory read data change on the falling edge
   initial begin
      void'($urandom(32'hd850_24d7));
      forever begin
         @(negedge clk_i);
         if (arst_n_i) begin
            if (iblk_cnt != 0) iblk_cnt--;
            else if ($urandom_range(3) == 0) iblk_cnt = $urandom_range(3);
            if (dblk_cnt != 0) dblk_cnt--;
            else if ($urandom_range(3) == 0) dblk_cnt = $urandom_range(3);
         end
         instr_blocking_n_i <= (iblk_cnt == 0);
         data_blocking_n_i  <= (dblk_cnt == 0);
         instr_data_i       <= imem[instr_addr_o[7:2]];
         data_rdata_i       <= dmem[data_addr_o[5:2]];
      end
   end

   // store scoreboard and byte-enabled memory
   always @(posedge clk_i) begin
      if (arst_n_i && data_en_o && data_blocking_n_i && data_we_o != 4'd0) begin
         if (exp_addr.size() == 0) begin
            errors++;
            $display("store after the end of the expected stream");
         end else begin
            assert (data_addr_o == exp_addr[0]) else begin
               errors++;
               $display("FAIL data_addr_o got %h expected %h", data_addr_o, exp_addr[0]);
            end
            assert (data_we_o == exp_we[0]) else begin
               errors++;
               $display("FAIL data_we_o got %h expected %h", data_we_o, exp_we[0]);
            end
            assert (data_wdata_o == exp_data[0]) else begin
               errors++;
               $display("FAIL data_wdata_o got %h expected %h", data_wdata_o, exp_data[0]);
            end
            if (exp_addr.size() == 1) done <= 1'b1;
            void'(exp_addr.pop_front());
            void'(exp_we.pop_front());
            void'(exp_data.pop_front());
         end
         for (int l = 0; l < 4; l++)
            if (data_we_o[l]) dmem[data_addr_o[5:2]][8*l +: 8] <= data_wdata_o[8*l +: 8];
      end
   end

   initial begin
      repeat (LIMIT + 5) @(posedge clk_i);
      errors++;
      $display("timeout, final store not seen after %0d cycles", LIMIT);
      $display("errors: %0d tb, %0d props", errors, dut.props_i.fail_cnt);
      $display("Testbench failed");
      $finish;
   end

   initial begin
      arst_n_i           = 1'b0;
      instr_blocking_n_i = 1'b1;
      data_blocking_n_i  = 1'b1;
      instr_data_i       = 32'd0;
      data_rdata_i       = 32'd0;
      foreach (imem[i]) imem[i] = (i < 31) ? PROG[i] : 32'd0;
      foreach (dmem[i]) dmem[i] = 32'd0;
      run_reference();
      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      arst_n_i <= 1'b1;
      wait (done);
      repeat (4) @(posedge clk_i);
      $display("errors: %0d tb, %0d props", errors, dut.props_i.fail_cnt);
      if (errors == 0 && dut.props_i.fail_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- verilog.f
+incdir+design
design/core_pkg.sv
design/stage_if.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/core.sv
tb/tb_clock.sv
tb/core_props.sv
tb/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM       := $(BUILD_DIR)/V$(TOP)
SRCS      := $(shell grep '\.sv$$' verilog.f) design/core_params.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): verilog.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f verilog.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(BUILD_DIR)
